/* rtl/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

`define AXI_ADDR_WIDTH   32
`define DATA_WIDTH       32
`define AXI_DATA_WIDTH   32
`define AXI_STRB_WIDTH   4
`define AXI_LEN_WIDTH    8
`define AXI_SIZE_WIDTH   3
`define AXI_BURST_WIDTH  2
`define AXI_RESP_WIDTH   2
`define AXI_ID_WIDTH     4

// axsize encodings, bytes per beat.
`define AXI_SIZE_1       3'b000
`define AXI_SIZE_2       3'b001
`define AXI_SIZE_4       3'b010

`define AXI_BURST_INCR   2'b01

// word addresses wrap modulo this depth.
`define MEM_DEPTH_WORDS  1024

`endif

/* rtl/mem_pkg.sv */
package mem_pkg;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_IFU,
        ARB_LSU
    } arb_state_e;  // owner of the shared read path.

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } bridge_rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } bridge_wr_state_e;

    typedef enum logic [1:0] {
        SL_IDLE,
        SL_READ,
        SL_WRITE,
        SL_RESP
    } slave_state_e;

endpackage

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_arbiter import mem_pkg::*; (
    input  logic                         aclk,
    input  logic                         areset_n,
    input  logic                         ifu_r_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ifu_r_addr_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    ifu_r_len_i,
    output logic                         ifu_r_ready_o,
    output logic [`DATA_WIDTH-1:0]       ifu_r_data_o,
    output logic                         ifu_r_last_o,
    input  logic                         lsu_r_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   lsu_r_addr_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   lsu_r_size_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    lsu_r_len_i,
    output logic                         lsu_r_ready_o,
    output logic [`DATA_WIDTH-1:0]       lsu_r_data_o,
    output logic                         lsu_r_last_o,
    input  logic                         lsu_w_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   lsu_w_addr_i,
    input  logic [`DATA_WIDTH-1:0]       lsu_w_data_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   lsu_w_size_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    lsu_w_len_i,
    output logic                         lsu_w_ready_o,
    output logic                         lsu_w_last_o,
    output logic                         cpu_r_valid_o,
    output logic [`AXI_ADDR_WIDTH-1:0]   cpu_r_addr_o,
    output logic [`AXI_SIZE_WIDTH-1:0]   cpu_r_size_o,
    output logic [`AXI_LEN_WIDTH-1:0]    cpu_r_len_o,
    input  logic                         cpu_r_ready_i,
    input  logic [`DATA_WIDTH-1:0]       cpu_r_data_i,
    input  logic                         cpu_r_last_i,
    output logic                         cpu_w_valid_o,
    output logic [`AXI_ADDR_WIDTH-1:0]   cpu_w_addr_o,
    output logic [`DATA_WIDTH-1:0]       cpu_w_data_o,
    output logic [`AXI_SIZE_WIDTH-1:0]   cpu_w_size_o,
    output logic [`AXI_LEN_WIDTH-1:0]    cpu_w_len_o,
    input  logic                         cpu_w_ready_i,
    input  logic                         cpu_w_last_i
);

    arb_state_e arb_state;
    logic       ifu_own;
    logic       lsu_own;
    logic       r_done;

    assign ifu_own = (arb_state == ARB_IFU);
    assign lsu_own = (arb_state == ARB_LSU);
    assign r_done  = cpu_r_ready_i & cpu_r_last_i;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            arb_state <= ARB_IDLE;
        end else begin
            case (arb_state)
                ARB_IDLE: begin
                    if (lsu_r_valid_i) begin
                        arb_state <= ARB_LSU;  // lsu wins a tie.
                    end else if (ifu_r_valid_i) begin
                        arb_state <= ARB_IFU;
                    end
                end
                ARB_IFU: begin
                    if (r_done) begin
                        arb_state <= lsu_r_valid_i ? ARB_LSU : ARB_IDLE;
                    end
                end
                ARB_LSU: begin
                    if (r_done) begin
                        arb_state <= ARB_IDLE;
                    end
                end
                default: arb_state <= ARB_IDLE;
            endcase
        end
    end

    assign cpu_r_valid_o = (ifu_own & ifu_r_valid_i) | (lsu_own & lsu_r_valid_i);
    assign cpu_r_addr_o  = ifu_own ? ifu_r_addr_i : (lsu_own ? lsu_r_addr_i : '0);
    assign cpu_r_size_o  = ifu_own ? `AXI_SIZE_4 : (lsu_own ? lsu_r_size_i : '0);
    assign cpu_r_len_o   = ifu_own ? ifu_r_len_i : (lsu_own ? lsu_r_len_i : '0);

    // beats go back only to the owner.
    assign ifu_r_ready_o = ifu_own & cpu_r_ready_i;
    assign ifu_r_data_o  = ifu_own ? cpu_r_data_i : '0;
    assign ifu_r_last_o  = ifu_own & cpu_r_last_i;
    assign lsu_r_ready_o = lsu_own & cpu_r_ready_i;
    assign lsu_r_data_o  = lsu_own ? cpu_r_data_i : '0;
    assign lsu_r_last_o  = lsu_own & cpu_r_last_i;

    assign cpu_w_valid_o = lsu_w_valid_i;  // writes bypass arbitration.
    assign cpu_w_addr_o  = lsu_w_addr_i;
    assign cpu_w_data_o  = lsu_w_data_i;
    assign cpu_w_size_o  = lsu_w_size_i;
    assign cpu_w_len_o   = lsu_w_len_i;
    assign lsu_w_ready_o = cpu_w_ready_i;
    assign lsu_w_last_o  = cpu_w_last_i;

endmodule

/* rtl/axi_master_bridge.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module axi_master_bridge import mem_pkg::*; (
    input  logic                         aclk,
    input  logic                         areset_n,
    input  logic                         cpu_r_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   cpu_r_addr_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   cpu_r_size_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    cpu_r_len_i,
    output logic                         cpu_r_ready_o,
    output logic [`DATA_WIDTH-1:0]       cpu_r_data_o,
    output logic                         cpu_r_last_o,
    input  logic                         cpu_w_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   cpu_w_addr_i,
    input  logic [`DATA_WIDTH-1:0]       cpu_w_data_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   cpu_w_size_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    cpu_w_len_i,
    output logic                         cpu_w_ready_o,
    output logic                         cpu_w_last_o,
    input  logic                         axi_aw_ready_i,
    output logic                         axi_aw_valid_o,
    output logic [`AXI_ADDR_WIDTH-1:0]   axi_aw_addr_o,
    output logic [`AXI_ID_WIDTH-1:0]     axi_aw_id_o,
    output logic [`AXI_LEN_WIDTH-1:0]    axi_aw_len_o,
    output logic [`AXI_SIZE_WIDTH-1:0]   axi_aw_size_o,
    output logic [`AXI_BURST_WIDTH-1:0]  axi_aw_burst_o,
    input  logic                         axi_w_ready_i,
    output logic                         axi_w_valid_o,
    output logic [`AXI_DATA_WIDTH-1:0]   axi_w_data_o,
    output logic [`AXI_STRB_WIDTH-1:0]   axi_w_strb_o,
    output logic                         axi_w_last_o,
    output logic                         axi_b_ready_o,
    input  logic                         axi_b_valid_i,
    input  logic [`AXI_RESP_WIDTH-1:0]   axi_b_resp_i,
    input  logic [`AXI_ID_WIDTH-1:0]     axi_b_id_i,
    input  logic                         axi_ar_ready_i,
    output logic                         axi_ar_valid_o,
    output logic [`AXI_ADDR_WIDTH-1:0]   axi_ar_addr_o,
    output logic [`AXI_ID_WIDTH-1:0]     axi_ar_id_o,
    output logic [`AXI_LEN_WIDTH-1:0]    axi_ar_len_o,
    output logic [`AXI_SIZE_WIDTH-1:0]   axi_ar_size_o,
    output logic [`AXI_BURST_WIDTH-1:0]  axi_ar_burst_o,
    output logic                         axi_r_ready_o,
    input  logic                         axi_r_valid_i,
    input  logic [`AXI_RESP_WIDTH-1:0]   axi_r_resp_i,
    input  logic [`AXI_DATA_WIDTH-1:0]   axi_r_data_i,
    input  logic                         axi_r_last_i,
    input  logic [`AXI_ID_WIDTH-1:0]     axi_r_id_i
);

    bridge_rd_state_e           rd_state;
    bridge_wr_state_e           wr_state;
    logic [`AXI_LEN_WIDTH-1:0]  wr_beat;
    logic                       r_beat;
    logic                       w_beat;
    logic                       b_done;

    assign axi_ar_valid_o = (rd_state == RD_ADDR);
    assign axi_r_ready_o  = (rd_state == RD_DATA);
    assign axi_ar_id_o    = '0;
    assign axi_ar_burst_o = `AXI_BURST_INCR;
    assign r_beat         = axi_r_ready_o & axi_r_valid_i & (axi_r_id_i == axi_ar_id_o);

    assign cpu_r_ready_o = r_beat;
    assign cpu_r_last_o  = r_beat & axi_r_last_i;
    assign cpu_r_data_o  = axi_r_data_i;

    assign axi_aw_valid_o = (wr_state == WR_ADDR);
    assign axi_w_valid_o  = (wr_state == WR_DATA);
    assign axi_b_ready_o  = (wr_state == WR_RESP);
    assign axi_aw_id_o    = '0;
    assign axi_aw_burst_o = `AXI_BURST_INCR;
    assign axi_w_last_o   = (wr_beat == axi_aw_len_o);
    assign w_beat         = axi_w_valid_o & axi_w_ready_i;
    assign b_done         = axi_b_ready_o & axi_b_valid_i & (axi_b_id_i == axi_aw_id_o);

    assign cpu_w_ready_o = w_beat;
    assign cpu_w_last_o  = b_done;

    // sub-word writes are single beat, so the latched address picks the lane.
    always_comb begin
        case (axi_aw_size_o)
            `AXI_SIZE_1: begin
                axi_w_strb_o = 4'b0001 << axi_aw_addr_o[1:0];
                axi_w_data_o = cpu_w_data_i << {axi_aw_addr_o[1:0], 3'b000};
            end
            `AXI_SIZE_2: begin
                axi_w_strb_o = 4'b0011 << {axi_aw_addr_o[1], 1'b0};
                axi_w_data_o = cpu_w_data_i << {axi_aw_addr_o[1], 4'b0000};
            end
            default: begin
                axi_w_strb_o = '1;
                axi_w_data_o = cpu_w_data_i;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            rd_state <= RD_IDLE;
            wr_state <= WR_IDLE;
            wr_beat  <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: if (cpu_r_valid_i) rd_state <= RD_ADDR;
                RD_ADDR: if (axi_ar_ready_i) rd_state <= RD_DATA;
                RD_DATA: if (r_beat && axi_r_last_i) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase

            case (wr_state)
                WR_IDLE: if (cpu_w_valid_i) wr_state <= WR_ADDR;
                WR_ADDR: if (axi_aw_ready_i) wr_state <= WR_DATA;
                WR_DATA: if (w_beat && axi_w_last_o) wr_state <= WR_RESP;
                WR_RESP: if (b_done) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase

            if (wr_state == WR_IDLE) begin
                wr_beat <= '0;
            end else if (w_beat) begin
                wr_beat <= wr_beat + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_state == RD_IDLE && cpu_r_valid_i) begin
            axi_ar_addr_o <= cpu_r_addr_i;
            axi_ar_len_o  <= cpu_r_len_i;
            axi_ar_size_o <= cpu_r_size_i;
        end
        if (wr_state == WR_IDLE && cpu_w_valid_i) begin
            axi_aw_addr_o <= cpu_w_addr_i;
            axi_aw_len_o  <= cpu_w_len_i;
            axi_aw_size_o <= cpu_w_size_i;
        end
    end

endmodule

/* rtl/axi_sram_slave.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module axi_sram_slave import mem_pkg::*; (
    input  logic                         aclk,
    input  logic                         areset_n,
    input  logic                         axi_aw_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   axi_aw_addr_i,
    input  logic [`AXI_ID_WIDTH-1:0]     axi_aw_id_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    axi_aw_len_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   axi_aw_size_i,
    input  logic [`AXI_BURST_WIDTH-1:0]  axi_aw_burst_i,
    output logic                         axi_aw_ready_o,
    input  logic                         axi_w_valid_i,
    input  logic [`AXI_DATA_WIDTH-1:0]   axi_w_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0]   axi_w_strb_i,
    input  logic                         axi_w_last_i,
    output logic                         axi_w_ready_o,
    input  logic                         axi_b_ready_i,
    output logic                         axi_b_valid_o,
    output logic [`AXI_RESP_WIDTH-1:0]   axi_b_resp_o,
    output logic [`AXI_ID_WIDTH-1:0]     axi_b_id_o,
    input  logic                         axi_ar_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   axi_ar_addr_i,
    input  logic [`AXI_ID_WIDTH-1:0]     axi_ar_id_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    axi_ar_len_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   axi_ar_size_i,
    input  logic [`AXI_BURST_WIDTH-1:0]  axi_ar_burst_i,
    output logic                         axi_ar_ready_o,
    input  logic                         axi_r_ready_i,
    output logic                         axi_r_valid_o,
    output logic [`AXI_RESP_WIDTH-1:0]   axi_r_resp_o,
    output logic [`AXI_DATA_WIDTH-1:0]   axi_r_data_o,
    output logic                         axi_r_last_o,
    output logic [`AXI_ID_WIDTH-1:0]     axi_r_id_o
);

    slave_state_e                sl_state;
    logic [`AXI_DATA_WIDTH-1:0]  mem [`MEM_DEPTH_WORDS];
    logic [`AXI_ADDR_WIDTH-1:0]  sl_addr;
    logic [`AXI_ADDR_WIDTH-1:0]  sl_step;
    logic [`AXI_ADDR_WIDTH-1:0]  word_idx;
    logic [`AXI_LEN_WIDTH-1:0]   sl_len;
    logic [`AXI_LEN_WIDTH-1:0]   sl_cnt;
    logic [`AXI_ID_WIDTH-1:0]    sl_id;
    logic                        aw_hs;
    logic                        ar_hs;
    logic                        w_hs;
    logic                        r_hs;

    assign axi_aw_ready_o = (sl_state == SL_IDLE);
    assign axi_ar_ready_o = (sl_state == SL_IDLE) & ~axi_aw_valid_i;  // write wins.
    assign axi_w_ready_o  = (sl_state == SL_WRITE);
    assign axi_r_valid_o  = (sl_state == SL_READ);
    assign axi_b_valid_o  = (sl_state == SL_RESP);

    assign aw_hs = axi_aw_valid_i & axi_aw_ready_o;
    assign ar_hs = axi_ar_valid_i & axi_ar_ready_o;
    assign w_hs  = axi_w_valid_i & axi_w_ready_o;
    assign r_hs  = axi_r_valid_o & axi_r_ready_i;

    assign word_idx     = (sl_addr >> 2) % `MEM_DEPTH_WORDS;
    assign axi_r_data_o = mem[word_idx];
    assign axi_r_last_o = axi_r_valid_o & (sl_cnt == sl_len);
    assign axi_r_resp_o = '0;  // always okay.
    assign axi_b_resp_o = '0;
    assign axi_r_id_o   = sl_id;
    assign axi_b_id_o   = sl_id;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            sl_state <= SL_IDLE;
            sl_cnt   <= '0;
        end else begin
            case (sl_state)
                SL_IDLE: begin
                    sl_cnt <= '0;
                    if (aw_hs) begin
                        sl_state <= SL_WRITE;
                    end else if (ar_hs) begin
                        sl_state <= SL_READ;
                    end
                end
                SL_READ: begin
                    if (r_hs) begin
                        sl_cnt <= sl_cnt + 1'b1;
                        if (axi_r_last_o) sl_state <= SL_IDLE;
                    end
                end
                SL_WRITE: begin
                    if (w_hs) begin
                        sl_cnt <= sl_cnt + 1'b1;
                        if (axi_w_last_i || sl_cnt == sl_len) sl_state <= SL_RESP;
                    end
                end
                SL_RESP: if (axi_b_ready_i) sl_state <= SL_IDLE;
                default: sl_state <= SL_IDLE;
            endcase
        end
    end

    // incrementing bursts step by the beat size.
    always_ff @(posedge aclk) begin
        if (aw_hs) begin
            sl_addr <= axi_aw_addr_i;
            sl_step <= `AXI_ADDR_WIDTH'(1) << axi_aw_size_i;
            sl_len  <= axi_aw_len_i;
            sl_id   <= axi_aw_id_i;
        end else if (ar_hs) begin
            sl_addr <= axi_ar_addr_i;
            sl_step <= `AXI_ADDR_WIDTH'(1) << axi_ar_size_i;
            sl_len  <= axi_ar_len_i;
            sl_id   <= axi_ar_id_i;
        end else if (w_hs || r_hs) begin
            sl_addr <= sl_addr + sl_step;
        end

        if (w_hs) begin
            for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
                if (axi_w_strb_i[i]) mem[word_idx][8*i +: 8] <= axi_w_data_i[8*i +: 8];
            end
        end
    end

endmodule

/* rtl/mem_subsys_top.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_subsys_top (
    input  logic                         aclk,
    input  logic                         areset_n,
    input  logic                         ifu_r_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ifu_r_addr_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    ifu_r_len_i,
    output logic                         ifu_r_ready_o,
    output logic [`DATA_WIDTH-1:0]       ifu_r_data_o,
    output logic                         ifu_r_last_o,
    input  logic                         lsu_r_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   lsu_r_addr_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   lsu_r_size_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    lsu_r_len_i,
    output logic                         lsu_r_ready_o,
    output logic [`DATA_WIDTH-1:0]       lsu_r_data_o,
    output logic                         lsu_r_last_o,
    input  logic                         lsu_w_valid_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   lsu_w_addr_i,
    input  logic [`DATA_WIDTH-1:0]       lsu_w_data_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   lsu_w_size_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    lsu_w_len_i,
    output logic                         lsu_w_ready_o,
    output logic                         lsu_w_last_o
);

    // nets carry the bridge's port names so the bridge connects by name.
    logic                         cpu_r_valid_i, cpu_r_ready_o, cpu_r_last_o;
    logic                         cpu_w_valid_i, cpu_w_ready_o, cpu_w_last_o;
    logic                         axi_aw_valid_o, axi_aw_ready_i, axi_w_valid_o, axi_w_ready_i;
    logic                         axi_w_last_o, axi_b_valid_i, axi_b_ready_o;
    logic                         axi_ar_valid_o, axi_ar_ready_i, axi_r_valid_i, axi_r_ready_o;
    logic                         axi_r_last_i;
    logic [`AXI_ADDR_WIDTH-1:0]   cpu_r_addr_i, cpu_w_addr_i, axi_aw_addr_o, axi_ar_addr_o;
    logic [`DATA_WIDTH-1:0]       cpu_r_data_o, cpu_w_data_i;
    logic [`AXI_DATA_WIDTH-1:0]   axi_w_data_o, axi_r_data_i;
    logic [`AXI_SIZE_WIDTH-1:0]   cpu_r_size_i, cpu_w_size_i, axi_aw_size_o, axi_ar_size_o;
    logic [`AXI_LEN_WIDTH-1:0]    cpu_r_len_i, cpu_w_len_i, axi_aw_len_o, axi_ar_len_o;
    logic [`AXI_ID_WIDTH-1:0]     axi_aw_id_o, axi_b_id_i, axi_ar_id_o, axi_r_id_i;
    logic [`AXI_BURST_WIDTH-1:0]  axi_aw_burst_o, axi_ar_burst_o;
    logic [`AXI_RESP_WIDTH-1:0]   axi_b_resp_i, axi_r_resp_i;
    logic [`AXI_STRB_WIDTH-1:0]   axi_w_strb_o;

    mem_arbiter i_arbiter (
        .cpu_r_valid_o (cpu_r_valid_i),
        .cpu_r_addr_o  (cpu_r_addr_i),
        .cpu_r_size_o  (cpu_r_size_i),
        .cpu_r_len_o   (cpu_r_len_i),
        .cpu_r_ready_i (cpu_r_ready_o),
        .cpu_r_data_i  (cpu_r_data_o),
        .cpu_r_last_i  (cpu_r_last_o),
        .cpu_w_valid_o (cpu_w_valid_i),
        .cpu_w_addr_o  (cpu_w_addr_i),
        .cpu_w_data_o  (cpu_w_data_i),
        .cpu_w_size_o  (cpu_w_size_i),
        .cpu_w_len_o   (cpu_w_len_i),
        .cpu_w_ready_i (cpu_w_ready_o),
        .cpu_w_last_i  (cpu_w_last_o),
        .*
    );

    axi_master_bridge i_bridge (.*);

    axi_sram_slave i_slave (
        .aclk           (aclk),
        .areset_n       (areset_n),
        .axi_aw_valid_i (axi_aw_valid_o),
        .axi_aw_addr_i  (axi_aw_addr_o),
        .axi_aw_id_i    (axi_aw_id_o),
        .axi_aw_len_i   (axi_aw_len_o),
        .axi_aw_size_i  (axi_aw_size_o),
        .axi_aw_burst_i (axi_aw_burst_o),
        .axi_aw_ready_o (axi_aw_ready_i),
        .axi_w_valid_i  (axi_w_valid_o),
        .axi_w_data_i   (axi_w_data_o),
        .axi_w_strb_i   (axi_w_strb_o),
        .axi_w_last_i   (axi_w_last_o),
        .axi_w_ready_o  (axi_w_ready_i),
        .axi_b_ready_i  (axi_b_ready_o),
        .axi_b_valid_o  (axi_b_valid_i),
        .axi_b_resp_o   (axi_b_resp_i),
        .axi_b_id_o     (axi_b_id_i),
        .axi_ar_valid_i (axi_ar_valid_o),
        .axi_ar_addr_i  (axi_ar_addr_o),
        .axi_ar_id_i    (axi_ar_id_o),
        .axi_ar_len_i   (axi_ar_len_o),
        .axi_ar_size_i  (axi_ar_size_o),
        .axi_ar_burst_i (axi_ar_burst_o),
        .axi_ar_ready_o (axi_ar_ready_i),
        .axi_r_ready_i  (axi_r_ready_o),
        .axi_r_valid_o  (axi_r_valid_i),
        .axi_r_resp_o   (axi_r_resp_i),
        .axi_r_data_o   (axi_r_data_i),
        .axi_r_last_o   (axi_r_last_i),
        .axi_r_id_o     (axi_r_id_i)
    );

endmodule

/* testbench/tb_mem_subsys.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_mem_subsys;

    localparam int CLK_PERIOD   = 4;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_TXNS     = 200;
    localparam int TXN_CYCLES   = 40;
    localparam int RAND_TXNS    = 80;
    localparam int RAND_WORDS   = 64;
    localparam logic [31:0] RAND_BASE = 32'h0000_0800;

    logic                        aclk;
    logic                        areset_n;
    logic                        ifu_r_valid_i;
    logic [`AXI_ADDR_WIDTH-1:0]  ifu_r_addr_i;
    logic [`AXI_LEN_WIDTH-1:0]   ifu_r_len_i;
    logic                        ifu_r_ready_o;
    logic [`DATA_WIDTH-1:0]      ifu_r_data_o;
    logic                        ifu_r_last_o;
    logic                        lsu_r_valid_i;
    logic [`AXI_ADDR_WIDTH-1:0]  lsu_r_addr_i;
    logic [`AXI_SIZE_WIDTH-1:0]  lsu_r_size_i;
    logic [`AXI_LEN_WIDTH-1:0]   lsu_r_len_i;
    logic                        lsu_r_ready_o;
    logic [`DATA_WIDTH-1:0]      lsu_r_data_o;
    logic                        lsu_r_last_o;
    logic                        lsu_w_valid_i;
    logic [`AXI_ADDR_WIDTH-1:0]  lsu_w_addr_i;
    logic [`DATA_WIDTH-1:0]      lsu_w_data_i;
    logic [`AXI_SIZE_WIDTH-1:0]  lsu_w_size_i;
    logic [`AXI_LEN_WIDTH-1:0]   lsu_w_len_i;
    logic                        lsu_w_ready_o;
    logic                        lsu_w_last_o;

    logic [7:0]   ref_mem [0:4*`MEM_DEPTH_WORDS-1];  // byte lane k of word w at 4*w+k.
    logic [31:0]  wr_data [0:7];                     // beats of the next write.
    integer       seed = 32'h0f741627;
    int           err_cnt = 0;
    int           check_cnt = 0;
    string        cur_test = "reset";

    // expected stream per read port, set when a request is raised.
    logic [31:0]  ifu_exp_addr;
    logic [31:0]  lsu_exp_addr;
    int           ifu_exp_len;
    int           lsu_exp_len;
    int           ifu_beat;
    int           lsu_beat;
    bit           ifu_active = 0;
    bit           lsu_active = 0;

    mem_subsys_top i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        int w;
        w = (addr >> 2) % `MEM_DEPTH_WORDS;
        return {ref_mem[4*w+3], ref_mem[4*w+2], ref_mem[4*w+1], ref_mem[4*w]};
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // sub-word data sits in the low bits and lands on the lane picked by the address.
    task automatic model_write(input logic [31:0] addr, input logic [2:0] size, input int len);
        int w;
        for (int b = 0; b <= len; b++) begin
            w = ((addr >> 2) + b) % `MEM_DEPTH_WORDS;
            if (size == `AXI_SIZE_1) begin
                ref_mem[4*w + addr[1:0]] = wr_data[0][7:0];
            end else if (size == `AXI_SIZE_2) begin
                ref_mem[4*w + {addr[1], 1'b0}]     = wr_data[0][7:0];
                ref_mem[4*w + {addr[1], 1'b0} + 1] = wr_data[0][15:8];
            end else begin
                for (int k = 0; k < 4; k++) begin
                    ref_mem[4*w + k] = wr_data[b][8*k +: 8];
                end
            end
        end
    endtask

    task automatic lsu_write(input logic [31:0] addr, input logic [2:0] size, input int len);
        int acc;
        bit done;
        acc = 0;
        done = 0;
        model_write(addr, size, len);
        @(posedge aclk);
        #DRIVE_DLY;
        lsu_w_valid_i = 1'b1;
        lsu_w_addr_i  = addr;
        lsu_w_size_i  = size;
        lsu_w_len_i   = len;
        lsu_w_data_i  = wr_data[0];
        while (!done) begin
            @(negedge aclk);
            if (lsu_w_ready_o) acc++;
            done = lsu_w_last_o;
            @(posedge aclk);
            #DRIVE_DLY;
            if (done) begin
                lsu_w_valid_i = 1'b0;  // one cycle after the response.
            end else if (acc <= len) begin
                lsu_w_data_i = wr_data[acc];
            end
        end
        check(acc, len + 1, "write beats accepted");
    endtask

    task automatic read_burst(input bit is_lsu, input logic [31:0] addr, input int len,
                              output time first_t, output time last_t);
        bit rdy;
        bit lst;
        bit seen;
        rdy = 0;
        lst = 0;
        seen = 0;
        first_t = 0;
        @(posedge aclk);
        #DRIVE_DLY;
        if (is_lsu) begin
            lsu_exp_addr  = addr;
            lsu_exp_len   = len;
            lsu_beat      = 0;
            lsu_active    = 1;
            lsu_r_valid_i = 1'b1;
            lsu_r_addr_i  = addr;
            lsu_r_len_i   = len;
            lsu_r_size_i  = `AXI_SIZE_4;
        end else begin
            ifu_exp_addr  = addr;
            ifu_exp_len   = len;
            ifu_beat      = 0;
            ifu_active    = 1;
            ifu_r_valid_i = 1'b1;
            ifu_r_addr_i  = addr;
            ifu_r_len_i   = len;
        end
        while (!lst) begin
            @(negedge aclk);
            rdy = is_lsu ? lsu_r_ready_o : ifu_r_ready_o;
            lst = rdy & (is_lsu ? lsu_r_last_o : ifu_r_last_o);
            if (rdy && !seen) begin
                first_t = $time;
                seen = 1;
            end
        end
        last_t = $time;
        @(posedge aclk);
        #DRIVE_DLY;
        if (is_lsu) lsu_r_valid_i = 1'b0;
        else ifu_r_valid_i = 1'b0;
    endtask

    // every strobe on a read port is checked against the reference model.
    always @(negedge aclk) begin
        if (ifu_r_ready_o) begin
            check(ifu_active, 1'b1, "ifu strobe without a pending request");
            check(ifu_r_data_o, ref_word(ifu_exp_addr + 4 * ifu_beat), "ifu read data");
            check(ifu_r_last_o, ifu_beat == ifu_exp_len, "ifu last flag");
            check(lsu_r_ready_o, 1'b0, "lsu strobe during an ifu burst");
            check(lsu_r_data_o, '0, "lsu data during an ifu burst");
            ifu_beat++;
            if (ifu_r_last_o) ifu_active = 0;
        end
        if (lsu_r_ready_o) begin
            check(lsu_active, 1'b1, "lsu strobe without a pending request");
            check(lsu_r_data_o, ref_word(lsu_exp_addr + 4 * lsu_beat), "lsu read data");
            check(lsu_r_last_o, lsu_beat == lsu_exp_len, "lsu last flag");
            check(ifu_r_data_o, '0, "ifu data during an lsu burst");
            lsu_beat++;
            if (lsu_r_last_o) lsu_active = 0;
        end
    end

    task automatic test_done(input int errs_before);
        if (err_cnt == errs_before) $display("test %s: ok", cur_test);
        else $display("test %s: %0d errors", cur_test, err_cnt - errs_before);
    endtask

    initial begin
        #((MAX_TXNS * TXN_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: test %s never completed its transactions", cur_test);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        time t_a;
        time t_b;
        time ifu_first;
        time lsu_last;
        int errs;
        int kind;
        int len;
        int off;
        logic [2:0] size;
        logic [31:0] addr;
        ifu_r_valid_i = 1'b0;
        ifu_r_addr_i  = '0;
        ifu_r_len_i   = '0;
        lsu_r_valid_i = 1'b0;
        lsu_r_addr_i  = '0;
        lsu_r_size_i  = '0;
        lsu_r_len_i   = '0;
        lsu_w_valid_i = 1'b0;
        lsu_w_addr_i  = '0;
        lsu_w_data_i  = '0;
        lsu_w_size_i  = '0;
        lsu_w_len_i   = '0;
        areset_n      = 1'b1;  // reset is active high.
        repeat (RESET_CYCLES) @(posedge aclk);
        #DRIVE_DLY;
        areset_n = 1'b0;

        cur_test = "single word write and read";
        errs = err_cnt;
        wr_data[0] = 32'ha5a5_1234;
        lsu_write(32'h40, `AXI_SIZE_4, 0);
        read_burst(1, 32'h40, 0, t_a, t_b);
        test_done(errs);

        cur_test = "4-beat write and ifu burst read";
        errs = err_cnt;
        for (int i = 0; i < 4; i++) wr_data[i] = 32'hc0de_0000 + i;
        lsu_write(32'h100, `AXI_SIZE_4, 3);
        read_burst(0, 32'h100, 3, t_a, t_b);
        test_done(errs);

        cur_test = "byte and half-word merge";
        errs = err_cnt;
        wr_data[0] = 32'h1122_3344;
        lsu_write(32'h200, `AXI_SIZE_4, 0);
        for (int i = 0; i < 4; i++) begin
            wr_data[0] = 32'hffff_ffa0 + i;  // upper bytes must not reach memory.
            lsu_write(32'h200 + i, `AXI_SIZE_1, 0);
            read_burst(1, 32'h200, 0, t_a, t_b);
        end
        for (int i = 0; i < 4; i += 2) begin
            wr_data[0] = 32'hffff_bee0 + i;
            lsu_write(32'h200 + i, `AXI_SIZE_2, 0);
            read_burst(1, 32'h200, 0, t_a, t_b);
        end
        test_done(errs);

        cur_test = "simultaneous ifu and lsu reads";
        errs = err_cnt;
        fork
            read_burst(0, 32'h100, 3, ifu_first, t_a);
            read_burst(1, 32'h100, 2, t_b, lsu_last);
        join
        check(lsu_last < ifu_first, 1'b1, "lsu last beat before first ifu beat");
        test_done(errs);

        cur_test = "ifu read during write burst";
        errs = err_cnt;
        for (int i = 0; i < 8; i++) wr_data[i] = 32'h5a00_0000 + 32'h11 * i;
        fork
            lsu_write(32'h300, `AXI_SIZE_4, 7);
            begin
                repeat (3) @(posedge aclk);
                read_burst(0, 32'h100, 3, t_a, t_b);
            end
        join
        read_burst(0, 32'h300, 7, t_a, t_b);
        test_done(errs);

        cur_test = "random mix";
        errs = err_cnt;
        for (int r = 0; r < RAND_WORDS / 8; r++) begin
            for (int i = 0; i < 8; i++) wr_data[i] = $random(seed);
            lsu_write(RAND_BASE + 32 * r, `AXI_SIZE_4, 7);
        end
        for (int n = 0; n < RAND_TXNS; n++) begin
            kind = rand_below(3);
            len  = rand_below(8);
            addr = RAND_BASE + 4 * rand_below(RAND_WORDS - len);
            if (kind < 2) begin
                read_burst(kind == 1, addr, len, t_a, t_b);
            end else begin
                size = `AXI_SIZE_4;
                off  = 0;
                if (len == 0) begin
                    case (rand_below(3))
                        0: begin
                            size = `AXI_SIZE_1;
                            off  = rand_below(4);
                        end
                        1: begin
                            size = `AXI_SIZE_2;
                            off  = 2 * rand_below(2);
                        end
                        default: size = `AXI_SIZE_4;
                    endcase
                end
                for (int i = 0; i < 8; i++) wr_data[i] = $random(seed);
                lsu_write(addr + off, size, len);
            end
        end
        test_done(errs);

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+rtl
rtl/mem_pkg.sv
rtl/mem_arbiter.sv
rtl/axi_master_bridge.sv
rtl/axi_sram_slave.sv
rtl/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_pkg.sv
      - rtl/mem_arbiter.sv
      - rtl/axi_master_bridge.sv
      - rtl/axi_sram_slave.sv
      - rtl/mem_subsys_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_mem_subsys.sv
